// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    localparam int index_bits = 4;
    localparam int way_count  = 2;
    localparam int tag_bits   = 32 - index_bits - 2;   // 26

    ////////////////////////////////////////
    // request address, two decodings
    ////////////////////////////////////////

    typedef union packed {
        // normal load / store lookup
        struct packed {
            logic [tag_bits-1:0]   tag;
            logic [index_bits-1:0] index;
            logic [1:0]            offset;
        } lookup;
        // index cache-ops
        struct packed {
            logic [tag_bits-1:0]   unused_hi;
            logic [index_bits-1:0] index;
            logic                  unused_lo;
            logic                  way_sel;    // which way the op hits
        } maint;
    } dcache_addr_u;

    typedef enum logic [1:0] {
        op_store_tag = 2'd0,    // zero tag, invalid
        op_index_inv = 2'd1,
        op_hit_inv   = 2'd2
    } cacheop_e;

endpackage

// ==== source/dcache_req_buffer.sv ====
`timescale 1ns/1ps

module dcache_req_buffer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     buffer_we,
    input  logic                     valid,
    input  logic                     write,
    input  logic                     uncached,
    input  logic                     cacheop_valid,
    input  dcache_pkg::cacheop_e     cacheop,
    input  logic [31:0]              addr,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    output logic                     req_write,
    output logic                     req_uncached,
    output logic                     req_cacheop_valid,
    output dcache_pkg::cacheop_e     req_cacheop,
    output dcache_pkg::dcache_addr_u lookup_addr,
    output logic [31:0]              req_wdata,
    output logic [3:0]               req_wstrb
);

    logic capture;

    assign capture = buffer_we && (valid || cacheop_valid);

    // kind bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_write         <= 1'b0;
            req_uncached      <= 1'b0;
            req_cacheop_valid <= 1'b0;
        end else if (capture) begin
            req_write         <= write && !cacheop_valid;   // cache-op wins
            req_uncached      <= uncached && !cacheop_valid;
            req_cacheop_valid <= cacheop_valid;
        end
    end

    // held through miss and store-through
    always_ff @(posedge clk) begin
        if (capture) begin
            req_cacheop <= cacheop;
            lookup_addr <= addr;        // seen as tag/index/offset or index/way
            req_wdata   <= wdata;
            req_wstrb   <= wstrb;
        end
    end

endmodule

// ==== source/dcache_way.sv ====
`timescale 1ns/1ps

module dcache_way (
    input  logic                     clk,
    input  logic                     rstn,
    input  dcache_pkg::dcache_addr_u lookup_addr,
    input  logic                     way_we,
    input  logic                     refill,
    input  logic [31:0]              refill_data,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     way_inv,
    input  logic                     tag_init,
    output logic                     hit,
    output logic [31:0]              rdata
);

    import dcache_pkg::*;

    localparam int sets = 2 ** index_bits;

    logic [sets-1:0]       valid_q;
    logic [tag_bits-1:0]   tag_mem  [sets];
    logic [31:0]           data_mem [sets];
    logic [index_bits-1:0] idx;
    logic [tag_bits-1:0]   req_tag;

    // index sits in the same bits for both views
    assign idx     = lookup_addr.lookup.index;
    assign req_tag = lookup_addr.lookup.tag;

    ////////////////////////////////////////
    // lookup
    ////////////////////////////////////////

    assign hit   = valid_q[idx] && (tag_mem[idx] == req_tag);
    assign rdata = data_mem[idx];

    ////////////////////////////////////////
    // updates
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (way_inv || tag_init) begin
            valid_q[idx] <= 1'b0;
        end else if (way_we && refill) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_init) begin
            tag_mem[idx] <= '0;
        end else if (way_we && refill) begin
            tag_mem[idx] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (way_we) begin
            if (refill) begin
                data_mem[idx] <= refill_data;   // whole word from memory
            end else begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b])
                        data_mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== source/dcache_way_merge.sv ====
`timescale 1ns/1ps

module dcache_way_merge (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic [dcache_pkg::index_bits-1:0]      index,
    input  logic [dcache_pkg::way_count-1:0]       way_hit,
    input  logic [dcache_pkg::way_count-1:0][31:0] way_rdata,
    input  logic [31:0]                            mem_rdata,
    input  logic                                   refill_sel,
    input  logic [dcache_pkg::way_count-1:0]       touch_way,
    output logic [dcache_pkg::way_count-1:0]       hit_vec,
    output logic                                   victim,
    output logic [31:0]                            rdata
);

    import dcache_pkg::*;

    localparam int sets = 2 ** index_bits;

    logic [sets-1:0] lru_q;         // set bit means way 1 is the older one
    logic [31:0]     refill_word;
    logic [31:0]     hit_word;

    assign hit_vec = way_hit;
    assign victim  = lru_q[index];

    // word of the mem_data_ok cycle, used one cycle later in refill
    always_ff @(posedge clk) begin
        refill_word <= mem_rdata;
    end

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < way_count; w++) begin
            if (way_hit[w])
                hit_word = way_rdata[w];
        end
    end

    assign rdata = refill_sel ? refill_word : hit_word;

    ////////////////////////////////////////
    // per-set lru
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (touch_way[0]) begin
            lru_q[index] <= 1'b1;
        end else if (touch_way[1]) begin
            lru_q[index] <= 1'b0;
        end
    end

endmodule

// ==== source/dcache_main_fsm.sv ====
`timescale 1ns/1ps

module dcache_main_fsm (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             valid,
    input  logic                             cacheop_valid,
    input  logic                             flush,
    input  logic                             req_write,
    input  logic                             req_uncached,
    input  logic                             req_cacheop_valid,
    input  dcache_pkg::cacheop_e             req_cacheop,
    input  dcache_pkg::dcache_addr_u         lookup_addr,
    input  logic [dcache_pkg::way_count-1:0] hit_vec,
    input  logic                             victim,
    input  logic                             mem_addr_ok,
    input  logic                             mem_data_ok,
    output logic                             ready,
    output logic                             buffer_we,
    output logic                             rdata_valid,
    output logic                             op_done,
    output logic                             mem_req,
    output logic                             mem_wr,
    output logic [dcache_pkg::way_count-1:0] way_we,
    output logic                             refill,
    output logic [dcache_pkg::way_count-1:0] way_inv,
    output logic [dcache_pkg::way_count-1:0] tag_init,
    output logic                             refill_sel,
    output logic [dcache_pkg::way_count-1:0] touch_way
);

    import dcache_pkg::*;

    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_lookup     = 3'd1;
    localparam logic [2:0] st_miss_read  = 3'd2;
    localparam logic [2:0] st_refill     = 3'd3;
    localparam logic [2:0] st_store_wait = 3'd4;
    localparam logic [2:0] st_operation  = 3'd5;
    localparam logic [2:0] st_flush      = 3'd6;

    logic [2:0] state;
    logic [2:0] next_state;
    logic [2:0] free_state;
    logic       miss;

    assign miss = !(|hit_vec) || req_uncached;   // uncached never served from a way

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= st_idle;
        else
            state <= next_state;
    end

    // where to go whenever ready is given back
    always_comb begin
        if (flush)
            free_state = st_flush;
        else if (cacheop_valid)
            free_state = st_operation;
        else if (valid)
            free_state = st_lookup;
        else
            free_state = st_idle;
    end

    ////////////////////////////////////////
    // next state and outputs
    ////////////////////////////////////////

    always_comb begin
        next_state  = state;
        ready       = 1'b0;
        buffer_we   = 1'b0;
        rdata_valid = 1'b0;
        op_done     = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        way_we      = '0;
        refill      = 1'b0;
        way_inv     = '0;
        tag_init    = '0;
        refill_sel  = 1'b0;
        touch_way   = '0;

        case (state)
            st_idle, st_flush: begin
                ready      = 1'b1;
                buffer_we  = 1'b1;
                next_state = free_state;
            end

            st_lookup: begin
                if (flush) begin
                    // drop the lookup, nothing goes to memory
                    ready      = 1'b1;
                    buffer_we  = 1'b1;
                    next_state = free_state;
                end else begin
                    if (req_uncached)
                        way_inv = hit_vec;
                    if (req_write) begin
                        mem_req = 1'b1;
                        mem_wr  = 1'b1;
                        if (!miss) begin
                            way_we    = hit_vec;    // write hit also updates the way
                            touch_way = hit_vec;
                        end
                        if (mem_addr_ok) begin
                            ready      = 1'b1;
                            buffer_we  = 1'b1;
                            next_state = free_state;
                        end else begin
                            next_state = st_store_wait;
                        end
                    end else if (miss) begin
                        mem_req    = 1'b1;
                        next_state = mem_data_ok ? st_refill : st_miss_read;
                    end else begin
                        rdata_valid = 1'b1;         // load hit
                        ready       = 1'b1;
                        buffer_we   = 1'b1;
                        touch_way   = hit_vec;
                        next_state  = free_state;
                    end
                end
            end

            st_miss_read: begin
                mem_req = 1'b1;
                if (mem_data_ok)
                    next_state = st_refill;
            end

            st_refill: begin
                rdata_valid = 1'b1;
                ready       = 1'b1;
                buffer_we   = 1'b1;
                refill_sel  = 1'b1;
                next_state  = free_state;
                if (!req_uncached) begin
                    refill            = 1'b1;
                    way_we[victim]    = 1'b1;
                    touch_way[victim] = 1'b1;
                end
            end

            st_store_wait: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    ready      = 1'b1;
                    buffer_we  = 1'b1;
                    next_state = free_state;
                end
            end

            st_operation: begin
                op_done    = 1'b1;
                ready      = 1'b1;
                buffer_we  = 1'b1;
                next_state = free_state;
                if (req_cacheop_valid) begin
                    case (req_cacheop)
                        op_store_tag: tag_init[lookup_addr.maint.way_sel] = 1'b1;
                        op_index_inv: way_inv[lookup_addr.maint.way_sel]  = 1'b1;
                        op_hit_inv:   way_inv = hit_vec;
                        default: ;
                    endcase
                end
            end

            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 rstn,
    // pipeline
    input  logic                 valid,
    input  logic                 write,
    input  logic                 uncached,
    input  logic                 cacheop_valid,
    input  dcache_pkg::cacheop_e cacheop,
    input  logic [31:0]          addr,
    input  logic [31:0]          wdata,
    input  logic [3:0]           wstrb,
    input  logic                 flush,
    output logic                 ready,
    output logic [31:0]          rdata,
    output logic                 rdata_valid,
    output logic                 op_done,
    // memory
    output logic                 mem_req,
    output logic                 mem_wr,
    output logic [31:0]          mem_addr,
    output logic [31:0]          mem_wdata,
    output logic [3:0]           mem_wstrb,
    input  logic                 mem_addr_ok,
    input  logic                 mem_data_ok,
    input  logic [31:0]          mem_rdata
);

    import dcache_pkg::*;

    logic                        buffer_we;
    logic                        req_write;
    logic                        req_uncached;
    logic                        req_cacheop_valid;
    cacheop_e                    req_cacheop;
    dcache_addr_u                lookup_addr;
    logic [31:0]                 req_wdata;
    logic [3:0]                  req_wstrb;
    logic [way_count-1:0]        way_hit;
    logic [way_count-1:0][31:0]  way_rdata;
    logic [way_count-1:0]        hit_vec;
    logic                        victim;
    logic [way_count-1:0]        way_we;
    logic                        refill;
    logic [way_count-1:0]        way_inv;
    logic [way_count-1:0]        tag_init;
    logic                        refill_sel;
    logic [way_count-1:0]        touch_way;

    // memory sees the held request
    assign mem_addr  = lookup_addr;
    assign mem_wdata = req_wdata;
    assign mem_wstrb = req_wstrb;

    dcache_req_buffer u_req_buffer (
        .clk               (clk),
        .rstn              (rstn),
        .buffer_we         (buffer_we),
        .valid             (valid),
        .write             (write),
        .uncached          (uncached),
        .cacheop_valid     (cacheop_valid),
        .cacheop           (cacheop),
        .addr              (addr),
        .wdata             (wdata),
        .wstrb             (wstrb),
        .req_write         (req_write),
        .req_uncached      (req_uncached),
        .req_cacheop_valid (req_cacheop_valid),
        .req_cacheop       (req_cacheop),
        .lookup_addr       (lookup_addr),
        .req_wdata         (req_wdata),
        .req_wstrb         (req_wstrb)
    );

    for (genvar way_id = 0; way_id < way_count; way_id++) begin : g_way
        dcache_way u_way (
            .clk         (clk),
            .rstn        (rstn),
            .lookup_addr (lookup_addr),
            .way_we      (way_we[way_id]),
            .refill      (refill),
            .refill_data (rdata),           // merge output carries the refill word
            .wdata       (req_wdata),
            .wstrb       (req_wstrb),
            .way_inv     (way_inv[way_id]),
            .tag_init    (tag_init[way_id]),
            .hit         (way_hit[way_id]),
            .rdata       (way_rdata[way_id])
        );
    end

    dcache_way_merge u_way_merge (
        .clk        (clk),
        .rstn       (rstn),
        .index      (lookup_addr.lookup.index),
        .way_hit    (way_hit),
        .way_rdata  (way_rdata),
        .mem_rdata  (mem_rdata),
        .refill_sel (refill_sel),
        .touch_way  (touch_way),
        .hit_vec    (hit_vec),
        .victim     (victim),
        .rdata      (rdata)
    );

    dcache_main_fsm u_main_fsm (
        .clk               (clk),
        .rstn              (rstn),
        .valid             (valid),
        .cacheop_valid     (cacheop_valid),
        .flush             (flush),
        .req_write         (req_write),
        .req_uncached      (req_uncached),
        .req_cacheop_valid (req_cacheop_valid),
        .req_cacheop       (req_cacheop),
        .lookup_addr       (lookup_addr),
        .hit_vec           (hit_vec),
        .victim            (victim),
        .mem_addr_ok       (mem_addr_ok),
        .mem_data_ok       (mem_data_ok),
        .ready             (ready),
        .buffer_we         (buffer_we),
        .rdata_valid       (rdata_valid),
        .op_done           (op_done),
        .mem_req           (mem_req),
        .mem_wr            (mem_wr),
        .way_we            (way_we),
        .refill            (refill),
        .way_inv           (way_inv),
        .tag_init          (tag_init),
        .refill_sel        (refill_sel),
        .touch_way         (touch_way)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// ==== verification/dcache_sva.sv ====
`timescale 1ns/1ps

module dcache_sva (
    input logic        clk,
    input logic        rstn,
    input logic        mem_req,
    input logic        mem_wr,
    input logic [31:0] mem_addr,
    input logic        mem_addr_ok,
    input logic        mem_data_ok,
    input logic        rdata_valid,
    input logic        op_done
);

    int   fail_count = 0;           // polled by the testbench
    logic req_open;

    // request still running after this cycle
    assign req_open = mem_req && !(mem_wr ? mem_addr_ok : mem_data_ok);

    assert property (@(posedge clk) disable iff (!rstn) req_open |=> mem_req)
    else begin
        $error("mem_req dropped before its ok strobe");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rstn) req_open |=> $stable(mem_addr))
    else begin
        $error("mem_addr changed while mem_req was held");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!rstn) !(rdata_valid && op_done))
    else begin
        $error("rdata_valid and op_done high in the same cycle");
        fail_count++;
    end

endmodule

bind dcache_top dcache_sva u_protocol_sva (
    .clk         (clk),
    .rstn        (rstn),
    .mem_req     (mem_req),
    .mem_wr      (mem_wr),
    .mem_addr    (mem_addr),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok),
    .rdata_valid (rdata_valid),
    .op_done     (op_done)
);

// ==== verification/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;

    import dcache_pkg::*;

    // about 80 requests of at most ~10 cycles each, plus reset
    localparam int max_cycles = 4000;
    localparam int any_mem    = 2;      // mem_req not predicted

    logic        clk;
    logic        rstn;
    logic        valid;
    logic        write;
    logic        uncached;
    logic        cacheop_valid;
    cacheop_e    cacheop;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        flush;
    logic        ready;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        op_done;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok = 1'b0;
    logic        mem_data_ok = 1'b0;
    logic [31:0] mem_rdata = '0;

    logic [31:0] mem_words [256];       // backing memory doubles as the shadow model
    logic [31:0] mem_rng;
    logic        mem_busy;
    logic [1:0]  mem_wait;
    logic [31:0] exp_addr;
    logic        exp_write;
    logic [3:0]  exp_wstrb;
    logic [31:0] exp_wdata;
    logic [31:0] expected_rdata;
    logic        saw_mem_req;
    logic [31:0] stim_rng;
    int          cycle_count = 0;
    string       test_name = "reset";

    tb_clock_gen u_clock_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    dcache_top UUT (
        .clk           (clk),
        .rstn          (rstn),
        .valid         (valid),
        .write         (write),
        .uncached      (uncached),
        .cacheop_valid (cacheop_valid),
        .cacheop       (cacheop),
        .addr          (addr),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .flush         (flush),
        .ready         (ready),
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .op_done       (op_done),
        .mem_req       (mem_req),
        .mem_wr        (mem_wr),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] line_addr(input int tag, input int set);
        return {26'(tag), 4'(set), 2'b00};
    endfunction

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    ////////////////////////////////////////
    // memory model, 0..3 cycles per access
    ////////////////////////////////////////

    always @(posedge clk) begin : memory_model
        logic [1:0] left;
        if (!rstn) begin
            for (int i = 0; i < 256; i++)
                mem_words[i] <= 32'h9e37_79b9 * (i + 1);
            mem_rng     <= 32'd3;
            mem_busy    <= 1'b0;
            mem_wait    <= 2'd0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            if (mem_req && (mem_addr_ok || mem_data_ok)) begin
                mem_busy <= 1'b0;       // transfer ends at this edge
                if (mem_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b])
                            mem_words[mem_addr[9:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                    end
                end
            end else if (mem_req) begin
                left = mem_busy ? mem_wait : mem_rng[1:0];
                if (!mem_busy)
                    mem_rng <= xorshift(mem_rng);
                mem_busy <= 1'b1;
                if (left == 2'd0) begin
                    mem_addr_ok <= mem_wr;
                    mem_data_ok <= !mem_wr;
                    mem_rdata   <= mem_words[mem_addr[9:2]];
                end else begin
                    mem_wait <= left - 2'd1;
                end
            end
        end
    end

    // what the accepted request should look like on the memory side
    always @(posedge clk) begin : request_monitor
        if (!rstn) begin
            exp_addr    <= '0;
            exp_write   <= 1'b0;
            exp_wstrb   <= '0;
            exp_wdata   <= '0;
            saw_mem_req <= 1'b0;
        end else if ((valid || cacheop_valid) && ready) begin
            exp_addr    <= addr;
            exp_write   <= write && valid;
            exp_wstrb   <= wstrb;
            exp_wdata   <= wdata;
            saw_mem_req <= 1'b0;
        end else if (mem_req) begin
            saw_mem_req <= 1'b1;
        end
    end

    assign expected_rdata = mem_words[exp_addr[9:2]];

    always @(posedge clk) begin : run_limit
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            abort_run();
        end else if (UUT.u_protocol_sva.fail_count != 0) begin
            $display("a bound protocol assertion failed during %s", test_name);
            abort_run();
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rstn)
        rdata_valid |-> (rdata == expected_rdata))
    else begin
        $display("FAILED %s: rdata expected %h, actual %h",
                 test_name, $sampled(expected_rdata), $sampled(rdata));
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> (mem_addr == exp_addr) && (mem_wr == exp_write))
    else begin
        $display("FAILED %s: mem_addr/mem_wr expected %h/%b, actual %h/%b", test_name,
                 $sampled(exp_addr), $sampled(exp_write), $sampled(mem_addr), $sampled(mem_wr));
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && mem_wr |-> (mem_wstrb == exp_wstrb) && (mem_wdata == exp_wdata))
    else begin
        $display("FAILED %s: store strobes/data expected %h/%h, actual %h/%h", test_name,
                 $sampled(exp_wstrb), $sampled(exp_wdata),
                 $sampled(mem_wstrb), $sampled(mem_wdata));
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rstn)
        cacheop_valid && ready && !flush |=> op_done)
    else begin
        $display("%s: op_done missing in the cycle after the cache-op", test_name);
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rstn)
        op_done |-> $past(cacheop_valid && ready))
    else begin
        $display("%s: op_done pulsed without a cache-op one cycle before", test_name);
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rstn) flush |-> ready && !mem_req)
    else begin
        $display("%s: ready low or mem_req high while flush is high", test_name);
        abort_run();
    end

    ////////////////////////////////////////
    // request tasks
    ////////////////////////////////////////

    task automatic wait_ready();
        do @(posedge clk); while (!ready);
    endtask

    task automatic check_mem_req(input int expect_req);
        @(posedge clk);                 // monitor has now taken the last cycle in
        if (expect_req != any_mem) begin
            assert (saw_mem_req == expect_req[0])
            else begin
                $display("FAILED %s: mem_req expected %0d, actual %0d",
                         test_name, expect_req, saw_mem_req);
                abort_run();
            end
        end
    endtask

    task automatic load_word(input string name, input logic [31:0] a, input logic unc,
                             input int expect_req);
        test_name = name;
        valid    <= 1'b1;
        write    <= 1'b0;
        uncached <= unc;
        addr     <= a;
        wait_ready();
        valid <= 1'b0;
        do @(posedge clk); while (!rdata_valid);
        check_mem_req(expect_req);
    endtask

    task automatic store_word(input string name, input logic [31:0] a, input logic [31:0] d,
                              input logic [3:0] strb, input logic unc);
        test_name = name;
        valid    <= 1'b1;
        write    <= 1'b1;
        uncached <= unc;
        addr     <= a;
        wdata    <= d;
        wstrb    <= strb;
        wait_ready();
        valid <= 1'b0;
        wait_ready();                   // ready comes back with mem_addr_ok
        check_mem_req(1);
    endtask

    task automatic run_cacheop(input string name, input cacheop_e op, input logic [31:0] a);
        test_name = name;
        cacheop_valid <= 1'b1;
        cacheop       <= op;
        addr          <= a;
        wait_ready();
        cacheop_valid <= 1'b0;
        do @(posedge clk); while (!op_done);
    endtask

    task automatic flushed_load(input string name, input logic [31:0] a, input int hold);
        test_name = name;
        valid    <= 1'b1;
        write    <= 1'b0;
        uncached <= 1'b0;
        addr     <= a;
        wait_ready();
        valid <= 1'b0;
        flush <= 1'b1;                  // lands in the lookup cycle
        repeat (hold) @(posedge clk);
        flush <= 1'b0;
        check_mem_req(0);
    endtask

    initial begin : stimulus
        logic [31:0] a;
        valid         = 1'b0;
        write         = 1'b0;
        uncached      = 1'b0;
        cacheop_valid = 1'b0;
        cacheop       = op_store_tag;
        addr          = '0;
        wdata         = '0;
        wstrb         = '0;
        flush         = 1'b0;
        stim_rng      = 32'd3;
        wait (rstn);
        @(posedge clk);

        load_word("load miss", line_addr(0, 1), 1'b0, 1);
        load_word("load hit", line_addr(0, 1), 1'b0, 0);
        load_word("load miss way 1", line_addr(1, 1), 1'b0, 1);
        load_word("load hit way 1", line_addr(1, 1), 1'b0, 0);

        store_word("store hit", line_addr(0, 1), 32'hdead_beef, 4'b0101, 1'b0);
        load_word("load after store hit", line_addr(0, 1), 1'b0, 0);
        store_word("store miss", line_addr(2, 2), 32'h1234_5678, 4'b1100, 1'b0);
        load_word("load after store miss", line_addr(2, 2), 1'b0, 1);
        load_word("load after refill", line_addr(2, 2), 1'b0, 0);

        // set 3: third tag evicts the oldest
        load_word("fill tag 0", line_addr(0, 3), 1'b0, 1);
        load_word("fill tag 1", line_addr(1, 3), 1'b0, 1);
        load_word("fill tag 2", line_addr(2, 3), 1'b0, 1);
        load_word("newest hits", line_addr(2, 3), 1'b0, 0);
        load_word("lru misses", line_addr(0, 3), 1'b0, 1);
        load_word("newest still hits", line_addr(2, 3), 1'b0, 0);

        load_word("cached before uncached", line_addr(0, 4), 1'b0, 1);
        load_word("uncached load", line_addr(0, 4), 1'b1, 1);
        load_word("load after uncached", line_addr(0, 4), 1'b0, 1);
        load_word("hit after refill", line_addr(0, 4), 1'b0, 0);
        store_word("uncached store", line_addr(0, 4), 32'h0bad_cafe, 4'b1111, 1'b1);
        load_word("load after uncached store", line_addr(0, 4), 1'b0, 1);

        load_word("fill for cache-ops", line_addr(0, 5), 1'b0, 1);
        load_word("fill other way", line_addr(1, 5), 1'b0, 1);
        run_cacheop("index invalidate way 0", op_index_inv, line_addr(0, 5));
        run_cacheop("index invalidate way 1", op_index_inv, line_addr(0, 5) | 32'd1);
        load_word("load after index invalidate", line_addr(0, 5), 1'b0, 1);
        load_word("other after index invalidate", line_addr(1, 5), 1'b0, 1);
        run_cacheop("hit invalidate", op_hit_inv, line_addr(0, 5));
        load_word("load after hit invalidate", line_addr(0, 5), 1'b0, 1);
        load_word("untouched way still hits", line_addr(1, 5), 1'b0, 0);
        run_cacheop("store tag way 0", op_store_tag, line_addr(0, 5));
        run_cacheop("store tag way 1", op_store_tag, line_addr(0, 5) | 32'd1);
        load_word("load after store tag", line_addr(1, 5), 1'b0, 1);

        flushed_load("flush in lookup", line_addr(0, 6), 5);
        load_word("load after flush", line_addr(0, 6), 1'b0, 1);

        // mixed traffic over eight sets, three tags each
        for (int n = 0; n < 40; n++) begin
            stim_rng = xorshift(stim_rng);
            a = line_addr(stim_rng[9:8] % 3, stim_rng[6:4]);
            if (stim_rng[0])
                store_word("random store", a, stim_rng ^ 32'h5a5a_0f0f, stim_rng[15:12],
                           stim_rng[20] && stim_rng[21]);
            else
                load_word("random load", a, stim_rng[22] && stim_rng[23], any_mem);
        end

        if (UUT.u_protocol_sva.fail_count != 0) begin
            $display("a bound protocol assertion failed");
            abort_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
source/dcache_pkg.sv
source/dcache_req_buffer.sv
source/dcache_way.sv
source/dcache_way_merge.sv
source/dcache_main_fsm.sv
source/dcache_top.sv
verification/tb_clock_gen.sv
verification/dcache_sva.sv
verification/dcache_tb.sv
